//--- usb_out_pkg.sv
////////////////////////////////////////
// USB OUT protocol engine definitions
// PIDs, bus field types and the strobe
// bundles between receiver, engine,
// transmitter and endpoints
////////////////////////////////////////

package usb_out_pkg;

  // PIDs handled by the OUT engine
  // Bit 3 of a data PID carries the toggle, low two bits give the type
  typedef enum logic [3:0] {
    UsbPidOut   = 4'b0001,
    UsbPidAck   = 4'b0010,
    UsbPidData0 = 4'b0011,
    UsbPidNak   = 4'b1010,
    UsbPidData1 = 4'b1011,
    UsbPidSetup = 4'b1101,
    UsbPidStall = 4'b1110
  } usb_pid_e;

  // PID type field of a token
  localparam logic [1:0] PidTypeToken = 2'b01;

  typedef logic [6:0] dev_addr_t;
  typedef logic [3:0] ep_id_t;
  typedef logic [7:0] byte_t;

  ////////////////////////////////////////
  // Receiver and transmitter bundles
  ////////////////////////////////////////

  // Packet framing from the receiver
  // pid, addr and endp hold while pkt_end is high
  typedef struct packed {
    logic      pkt_start;
    logic      pkt_end;
    logic      pkt_valid;
    usb_pid_e  pid;
    dev_addr_t addr;
    ep_id_t    endp;
  } rx_pkt_t;

  // One received payload byte per put strobe
  typedef struct packed {
    logic  put;
    byte_t data;
  } rx_data_t;

  // Handshake request, pid only valid with start
  typedef struct packed {
    logic     start;
    usb_pid_e pid;
  } tx_hs_t;

  ////////////////////////////////////////
  // Engine internal and endpoint bundles
  ////////////////////////////////////////

  // Classification of the packet ending this cycle
  typedef struct packed {
    logic out_tok;
    logic setup_tok;
    logic data_pkt;
    logic bad_pkt;
    logic toggle_bit;
    logic ep_hit;
  } rx_class_t;

  // Per transaction events to the endpoint side
  typedef struct packed {
    logic newpkt;
    logic acked;
    logic rollback;
  } ep_event_t;

endpackage

//--- usb_out_token_decode.sv
////////////////////////////////////////
// USB OUT token decoder
// Classifies the packet ending this cycle
// and looks up the addressed endpoint
////////////////////////////////////////

module usb_out_token_decode #(
  parameter int unsigned NumOutEps = 2
) (
  input  usb_out_pkg::rx_pkt_t   rx_pkt_i,
  input  usb_out_pkg::dev_addr_t dev_addr_i,
  input  logic [NumOutEps-1:0]   ep_enabled_i,
  input  logic [NumOutEps-1:0]   ep_control_i,
  input  logic [NumOutEps-1:0]   data_toggle_i,
  output usb_out_pkg::rx_class_t class_o,
  output logic [EpIdxW-1:0]      ep_idx_o,
  output logic                   ep_control_o,
  output logic                   toggle_bad_o
);

  localparam int unsigned EpIdxW = (NumOutEps > 1) ? $clog2(NumOutEps) : 1;
  localparam logic [4:0] NumEps = 5'(NumOutEps);

  logic token_hit;
  logic is_data_pid;
  logic ep_in_hw;

  // Token for this device, any token PID
  assign token_hit = rx_pkt_i.pkt_end && rx_pkt_i.pkt_valid &&
                     (rx_pkt_i.pid[1:0] == usb_out_pkg::PidTypeToken) &&
                     (rx_pkt_i.addr == dev_addr_i);

  assign is_data_pid = (rx_pkt_i.pid == usb_out_pkg::UsbPidData0) ||
                       (rx_pkt_i.pid == usb_out_pkg::UsbPidData1);

  // Endpoint numbers beyond the implemented range fold to 0
  assign ep_in_hw = {1'b0, rx_pkt_i.endp} < NumEps;
  assign ep_idx_o = ep_in_hw ? rx_pkt_i.endp[EpIdxW-1:0] : '0;

  always_comb begin
    class_o.out_tok    = token_hit && (rx_pkt_i.pid == usb_out_pkg::UsbPidOut);
    class_o.setup_tok  = token_hit && (rx_pkt_i.pid == usb_out_pkg::UsbPidSetup);
    class_o.data_pkt   = rx_pkt_i.pkt_end && rx_pkt_i.pkt_valid && is_data_pid;
    // CRC failure or an unexpected PID in the data slot
    class_o.bad_pkt    = rx_pkt_i.pkt_end && !(rx_pkt_i.pkt_valid && is_data_pid);
    class_o.toggle_bit = rx_pkt_i.pid[3];
    // Implemented and switched on by the endpoint side
    class_o.ep_hit     = ep_in_hw && ep_enabled_i[ep_idx_o];
  end

  assign ep_control_o = ep_control_i[ep_idx_o];

  // Data PID disagrees with the stored toggle, host missed our ACK
  assign toggle_bad_o = class_o.data_pkt && class_o.ep_hit &&
                        (class_o.toggle_bit != data_toggle_i[ep_idx_o]);

endmodule

//--- usb_out_xact_fsm.sv
////////////////////////////////////////
// USB OUT transaction state machine
// Token, data packet with timeout, then
// the handshake choice at data end
////////////////////////////////////////

module usb_out_xact_fsm #(
  parameter int unsigned AckTimeoutCnt = 68
) (
  input  logic                   clk_48mhz_i,
  input  logic                   rst_ni,
  input  logic                   link_reset_i,
  input  logic                   pkt_start_i,
  input  usb_out_pkg::rx_class_t class_i,
  input  logic                   ep_control_i,
  input  logic                   toggle_bad_i,
  input  logic                   setup_xact_i,
  input  logic                   full_i,
  input  logic                   stall_i,
  input  logic                   nak_i,
  output usb_out_pkg::tx_hs_t    tx_o,
  output logic                   xact_start_o,
  output logic                   new_pkt_end_o,
  output usb_out_pkg::ep_event_t event_o,
  output logic                   in_data_o,
  output logic                   clear_addr_o
);

  localparam int unsigned CntW = $clog2(AckTimeoutCnt + 1);
  localparam logic [CntW-1:0] CntLoad = CntW'(AckTimeoutCnt);

  typedef enum logic [1:0] {
    StIdle,
    StWaitData,
    StRcvData,
    StDataEnd
  } xact_state_e;

  xact_state_e     state_q, state_d;
  logic [CntW-1:0] timeout_q;

  ////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    tx_o.start    = 1'b0;
    tx_o.pid      = usb_out_pkg::UsbPidAck;
    xact_start_o  = 1'b0;
    new_pkt_end_o = 1'b0;
    event_o       = '0;

    unique case (state_q)
      StIdle: begin
        // SETUP only accepted on control endpoints
        if (class_i.ep_hit &&
            (class_i.out_tok || (class_i.setup_tok && ep_control_i))) begin
          state_d        = StWaitData;
          xact_start_o   = 1'b1;
          event_o.newpkt = 1'b1;
        end
      end

      StWaitData: begin
        // Data packet must start before the countdown runs out
        if (pkt_start_i) begin
          state_d = StRcvData;
        end else if (timeout_q == '0) begin
          state_d = StIdle;
        end
      end

      StRcvData: begin
        if (toggle_bad_i && !stall_i) begin
          // Repeat of an already accepted packet, ACK again and drop it
          state_d          = StIdle;
          event_o.rollback = 1'b1;
          tx_o.start       = 1'b1;
          tx_o.pid         = usb_out_pkg::UsbPidAck;
        end else if (class_i.bad_pkt) begin
          // Corrupt packet gets no answer at all
          state_d          = StIdle;
          event_o.rollback = 1'b1;
        end else if (class_i.data_pkt) begin
          state_d = StDataEnd;
        end
      end

      StDataEnd: begin
        state_d    = StIdle;
        tx_o.start = 1'b1;
        if (setup_xact_i) begin
          // SETUP is never NAKed, a lost one stays silent
          if (nak_i || full_i) begin
            tx_o.start       = 1'b0;
            event_o.rollback = 1'b1;
          end else begin
            tx_o.pid      = usb_out_pkg::UsbPidAck;
            new_pkt_end_o = 1'b1;
            event_o.acked = 1'b1;
          end
        end else if (stall_i) begin
          tx_o.pid = usb_out_pkg::UsbPidStall;
        end else if (nak_i || full_i) begin
          // No room, host retries later
          tx_o.pid         = usb_out_pkg::UsbPidNak;
          event_o.rollback = 1'b1;
        end else begin
          tx_o.pid      = usb_out_pkg::UsbPidAck;
          new_pkt_end_o = 1'b1;
          event_o.acked = 1'b1;
        end
      end

      default: state_d = StIdle;
    endcase
  end

  // Receiving state gates the byte puts
  assign in_data_o    = (state_q == StRcvData);
  assign clear_addr_o = (state_q == StWaitData) && pkt_start_i;

  ////////////////////////////////////////
  // State and timeout registers
  ////////////////////////////////////////

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
    end else if (link_reset_i) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Reloads outside the wait state
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      timeout_q <= CntLoad;
    end else if (state_q == StWaitData) begin
      timeout_q <= timeout_q - 1'b1;
    end else begin
      timeout_q <= CntLoad;
    end
  end

  state_legal_a : assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    state_q inside {StIdle, StWaitData, StRcvData, StDataEnd});

  // Handshakes only ever answer a data packet
  tx_in_data_phase_a : assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    tx_o.start |-> !(state_q inside {StIdle, StWaitData}));

endmodule

//--- usb_out_data_path.sv
////////////////////////////////////////
// USB OUT data path
// Byte register, delayed put strobe,
// put offset counter and NAK-on-full
////////////////////////////////////////

module usb_out_data_path #(
  parameter int unsigned MaxOutPktSizeByte = 32
) (
  input  logic                  clk_48mhz_i,
  input  logic                  rst_ni,
  input  usb_out_pkg::rx_data_t rx_data_i,
  input  logic                  in_data_i,
  input  logic                  clear_addr_i,
  input  logic                  full_i,
  output logic                  put_o,
  output logic [PktW-1:0]       put_addr_o,
  output usb_out_pkg::byte_t    data_o,
  output logic                  nak_o
);

  localparam int unsigned PktW = $clog2(MaxOutPktSizeByte);

  logic addr_inc;

  // Payload byte, captured on every rx put
  always_ff @(posedge clk_48mhz_i) begin
    if (rx_data_i.put) begin
      data_o <= rx_data_i.data;
    end
  end

  // Put follows the rx strobe by one cycle, together with the byte
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      put_o <= 1'b0;
    end else begin
      put_o <= in_data_i && rx_data_i.put;
    end
  end

  // Any byte landing on a full endpoint NAKs the whole packet
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nak_o <= 1'b0;
    end else if (!in_data_i) begin
      nak_o <= 1'b0;
    end else if (put_o && full_i) begin
      nak_o <= 1'b1;
    end
  end

  // Offset freezes once a NAK is due and saturates at all ones
  assign addr_inc = put_o && !nak_o && !(&put_addr_o);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      put_addr_o <= '0;
    end else if (clear_addr_i) begin
      put_addr_o <= '0;
    end else if (addr_inc) begin
      put_addr_o <= put_addr_o + 1'b1;
    end
  end

  put_addr_no_wrap_a : assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    (&put_addr_o && !clear_addr_i) |=> (put_addr_o != '0));

endmodule

//--- usb_out_toggle_regs.sv
////////////////////////////////////////
// USB OUT data toggles and SETUP flags
// Per endpoint, with masked software write
////////////////////////////////////////

module usb_out_toggle_regs #(
  parameter int unsigned NumOutEps = 2
) (
  input  logic                 clk_48mhz_i,
  input  logic                 rst_ni,
  input  logic                 link_reset_i,
  input  logic                 setup_hit_i,
  input  logic                 out_hit_i,
  input  logic [EpIdxW-1:0]    tok_idx_i,
  input  logic [EpIdxW-1:0]    cur_idx_i,
  input  logic                 flip_i,
  input  logic                 sw_we_i,
  input  logic [NumOutEps-1:0] sw_status_i,
  input  logic [NumOutEps-1:0] sw_mask_i,
  output logic [NumOutEps-1:0] toggle_o,
  output logic [NumOutEps-1:0] setup_o
);

  localparam int unsigned EpIdxW = (NumOutEps > 1) ? $clog2(NumOutEps) : 1;

  logic [NumOutEps-1:0] toggle_d;

  always_comb begin
    toggle_d = toggle_o;
    // SETUP always restarts the sequence at DATA0
    if (setup_hit_i) begin
      toggle_d[tok_idx_i] = 1'b0;
    end else if (flip_i) begin
      toggle_d[cur_idx_i] = ~toggle_o[cur_idx_i];
    end
    // Software wins on the masked bits
    if (sw_we_i) begin
      toggle_d = (toggle_d & ~sw_mask_i) | (sw_status_i & sw_mask_i);
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      toggle_o <= '0;
    end else if (link_reset_i) begin
      toggle_o <= '0;
    end else begin
      toggle_o <= toggle_d;
    end
  end

  // Marks the endpoint whose last token was a SETUP
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      setup_o <= '0;
    end else if (setup_hit_i) begin
      setup_o[tok_idx_i] <= 1'b1;
    end else if (out_hit_i) begin
      setup_o[tok_idx_i] <= 1'b0;
    end
  end

endmodule

//--- usb_out_pe.sv
////////////////////////////////////////
// USB full-speed OUT/SETUP engine
// Unbuffered, bytes go straight to the
// endpoint with a put offset, answered by
// ACK, NAK, STALL or silence
////////////////////////////////////////

module usb_out_pe #(
  parameter int unsigned NumOutEps         = 2,
  parameter int unsigned MaxOutPktSizeByte = 32,
  parameter int unsigned AckTimeoutCnt     = 68
) (
  input  logic                   clk_48mhz_i,
  input  logic                   rst_ni,
  input  logic                   link_reset_i,
  input  usb_out_pkg::dev_addr_t dev_addr_i,

  // Receiver and transmitter
  input  usb_out_pkg::rx_pkt_t   rx_pkt_i,
  input  usb_out_pkg::rx_data_t  rx_data_i,
  output usb_out_pkg::tx_hs_t    tx_o,

  // Endpoint side
  output usb_out_pkg::ep_id_t    ep_current_o,
  output logic                   ep_put_o,
  output logic [PktW-1:0]        ep_put_addr_o,
  output usb_out_pkg::byte_t     ep_data_o,
  output usb_out_pkg::ep_event_t ep_event_o,
  output logic [NumOutEps-1:0]   ep_setup_o,
  input  logic [NumOutEps-1:0]   ep_enabled_i,
  input  logic [NumOutEps-1:0]   ep_control_i,
  input  logic [NumOutEps-1:0]   ep_full_i,
  input  logic [NumOutEps-1:0]   ep_stall_i,

  // Software toggle access
  output logic [NumOutEps-1:0]   data_toggle_o,
  input  logic                   datatog_we_i,
  input  logic [NumOutEps-1:0]   datatog_status_i,
  input  logic [NumOutEps-1:0]   datatog_mask_i
);

  localparam int unsigned EpIdxW = (NumOutEps > 1) ? $clog2(NumOutEps) : 1;
  localparam int unsigned PktW   = $clog2(MaxOutPktSizeByte);

  usb_out_pkg::rx_class_t rx_class;
  usb_out_pkg::ep_event_t fsm_event;
  logic [EpIdxW-1:0]      tok_idx;
  logic [EpIdxW-1:0]      cur_idx;
  logic                   tok_control;
  logic                   toggle_bad;
  logic                   xact_start;
  logic                   new_pkt_end;
  logic                   in_data;
  logic                   clear_addr;
  logic                   nak_q;
  logic                   setup_xact_q;
  logic                   newpkt_q;

  ////////////////////////////////////////
  // Current transaction
  ////////////////////////////////////////

  // Endpoint and type stay put for the whole transaction
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ep_current_o <= '0;
      setup_xact_q <= 1'b0;
      newpkt_q     <= 1'b0;
    end else begin
      newpkt_q <= fsm_event.newpkt;
      if (xact_start) begin
        ep_current_o <= usb_out_pkg::ep_id_t'(tok_idx);
        setup_xact_q <= rx_class.setup_tok;
      end
    end
  end

  assign cur_idx = ep_current_o[EpIdxW-1:0];

  always_comb begin
    ep_event_o          = fsm_event;
    ep_event_o.newpkt   = newpkt_q;
  end

  ////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////

  usb_out_token_decode #(
    .NumOutEps (NumOutEps)
  ) i_token_decode (
    .rx_pkt_i      (rx_pkt_i),
    .dev_addr_i    (dev_addr_i),
    .ep_enabled_i  (ep_enabled_i),
    .ep_control_i  (ep_control_i),
    .data_toggle_i (data_toggle_o),
    .class_o       (rx_class),
    .ep_idx_o      (tok_idx),
    .ep_control_o  (tok_control),
    .toggle_bad_o  (toggle_bad)
  );

  usb_out_xact_fsm #(
    .AckTimeoutCnt (AckTimeoutCnt)
  ) i_xact_fsm (
    .clk_48mhz_i   (clk_48mhz_i),
    .rst_ni        (rst_ni),
    .link_reset_i  (link_reset_i),
    .pkt_start_i   (rx_pkt_i.pkt_start),
    .class_i       (rx_class),
    .ep_control_i  (tok_control),
    .toggle_bad_i  (toggle_bad),
    .setup_xact_i  (setup_xact_q),
    .full_i        (ep_full_i[cur_idx]),
    .stall_i       (ep_stall_i[cur_idx]),
    .nak_i         (nak_q),
    .tx_o          (tx_o),
    .xact_start_o  (xact_start),
    .new_pkt_end_o (new_pkt_end),
    .event_o       (fsm_event),
    .in_data_o     (in_data),
    .clear_addr_o  (clear_addr)
  );

  usb_out_data_path #(
    .MaxOutPktSizeByte (MaxOutPktSizeByte)
  ) i_data_path (
    .clk_48mhz_i  (clk_48mhz_i),
    .rst_ni       (rst_ni),
    .rx_data_i    (rx_data_i),
    .in_data_i    (in_data),
    .clear_addr_i (clear_addr),
    .full_i       (ep_full_i[cur_idx]),
    .put_o        (ep_put_o),
    .put_addr_o   (ep_put_addr_o),
    .data_o       (ep_data_o),
    .nak_o        (nak_q)
  );

  // Toggle and SETUP flag follow the token whatever the endpoint type
  usb_out_toggle_regs #(
    .NumOutEps (NumOutEps)
  ) i_toggle_regs (
    .clk_48mhz_i  (clk_48mhz_i),
    .rst_ni       (rst_ni),
    .link_reset_i (link_reset_i),
    .setup_hit_i  (rx_class.setup_tok && rx_class.ep_hit),
    .out_hit_i    (rx_class.out_tok && rx_class.ep_hit),
    .tok_idx_i    (tok_idx),
    .cur_idx_i    (cur_idx),
    .flip_i       (new_pkt_end),
    .sw_we_i      (datatog_we_i),
    .sw_status_i  (datatog_status_i),
    .sw_mask_i    (datatog_mask_i),
    .toggle_o     (data_toggle_o),
    .setup_o      (ep_setup_o)
  );

endmodule

//--- tb_clk_gen.sv
////////////////////////////////////////
// Testbench clock and reset
// 40 ns clock, reset low for 8 cycles
////////////////////////////////////////

module tb_clk_gen #(
  parameter int unsigned PeriodNs  = 40,
  parameter int unsigned RstCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- tb_usb_out_pe.sv
////////////////////////////////////////
// Testbench for the USB OUT engine
// Directed OUT and SETUP transactions,
// handshake, put and toggle checks
////////////////////////////////////////

module tb_usb_out_pe;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumOutEps         = 2;
  localparam int unsigned MaxOutPktSizeByte = 32;
  localparam int unsigned AckTimeoutCnt     = 68;
  localparam int unsigned PktW              = $clog2(MaxOutPktSizeByte);
  // Roughly 300 cycles of traffic so the limit only trips on a hang
  localparam int          CycLimit          = 4000;
  localparam usb_out_pkg::dev_addr_t DevAddr = 7'h2a;

  logic                   clk_48mhz;
  logic                   rst_n;
  logic                   link_reset;
  logic                   datatog_we;
  logic                   ep_put;
  logic [PktW-1:0]        ep_put_addr;
  usb_out_pkg::dev_addr_t dev_addr;
  usb_out_pkg::rx_pkt_t   rx_pkt;
  usb_out_pkg::rx_data_t  rx_data;
  usb_out_pkg::tx_hs_t    tx;
  usb_out_pkg::ep_id_t    ep_current;
  usb_out_pkg::byte_t     ep_data;
  usb_out_pkg::ep_event_t ep_event;
  logic [NumOutEps-1:0]   ep_setup, ep_enabled, ep_control, ep_full, ep_stall;
  logic [NumOutEps-1:0]   data_toggle, datatog_status, datatog_mask;

  // Monitor log sampled on the falling edge
  usb_out_pkg::tx_hs_t    tx_q[$];
  usb_out_pkg::ep_event_t ev_q[$];
  usb_out_pkg::byte_t     put_data_q[$];
  usb_out_pkg::byte_t     payload[$];
  logic [PktW-1:0]        put_addr_q[$];
  int                     tx_cyc_q[$];
  int                     ev_cyc_q[$];
  int                     newpkt_cnt;
  logic [NumOutEps-1:0]   tog_seen, setup_seen, exp_tog, exp_setup;
  usb_out_pkg::ep_id_t    cur_seen;
  int                     cyc;
  int                     n_checks;
  int                     n_errors;
  integer                 seed = 32'h898c;

  tb_clk_gen #(.PeriodNs(40), .RstCycles(8)) i_clk_gen (.clk_o(clk_48mhz), .rst_no(rst_n));

  usb_out_pe #(
    .NumOutEps         (NumOutEps),
    .MaxOutPktSizeByte (MaxOutPktSizeByte),
    .AckTimeoutCnt     (AckTimeoutCnt)
  ) i_usb_out_pe (
    .clk_48mhz_i      (clk_48mhz),
    .rst_ni           (rst_n),
    .link_reset_i     (link_reset),
    .dev_addr_i       (dev_addr),
    .rx_pkt_i         (rx_pkt),
    .rx_data_i        (rx_data),
    .tx_o             (tx),
    .ep_current_o     (ep_current),
    .ep_put_o         (ep_put),
    .ep_put_addr_o    (ep_put_addr),
    .ep_data_o        (ep_data),
    .ep_event_o       (ep_event),
    .ep_setup_o       (ep_setup),
    .ep_enabled_i     (ep_enabled),
    .ep_control_i     (ep_control),
    .ep_full_i        (ep_full),
    .ep_stall_i       (ep_stall),
    .data_toggle_o    (data_toggle),
    .datatog_we_i     (datatog_we),
    .datatog_status_i (datatog_status),
    .datatog_mask_i   (datatog_mask)
  );

  ////////////////////////////////////////
  // Cycle count, timeout and monitor
  ////////////////////////////////////////

  always @(posedge clk_48mhz or negedge rst_n) begin
    if (!rst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  always @(posedge clk_48mhz) begin
    if (cyc >= CycLimit) begin
      $display("Timeout: the tests did not finish within %0d cycles", CycLimit);
      $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  always @(negedge clk_48mhz) begin
    if (rst_n) begin
      tog_seen   = data_toggle;
      setup_seen = ep_setup;
      cur_seen   = ep_current;
      if (tx.start) begin
        tx_q.push_back(tx);
        tx_cyc_q.push_back(cyc);
      end
      if (ep_event.newpkt) begin
        newpkt_cnt++;
      end
      if (ep_event.acked || ep_event.rollback) begin
        ev_q.push_back(ep_event);
        ev_cyc_q.push_back(cyc);
      end
      if (ep_put) begin
        put_addr_q.push_back(ep_put_addr);
        put_data_q.push_back(ep_data);
      end
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    n_errors++;
    $display("Mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
  endtask

  task automatic check_hs(input usb_out_pkg::tx_hs_t got, exp, input string what);
    n_checks++;
    if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic check_event(input usb_out_pkg::ep_event_t got, exp, input string what);
    n_checks++;
    if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic check_byte(input usb_out_pkg::byte_t got, exp, input string what);
    n_checks++;
    if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic check_offset(input logic [PktW-1:0] got, exp, input string what);
    n_checks++;
    if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic check_vec(input logic [NumOutEps-1:0] got, exp, input string what);
    n_checks++;
    if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic check_count(input int got, exp, input string what);
    n_checks++;
    if (got != exp) report_mismatch(what, got, exp);
  endtask

  // Handshake and end event are each absent or seen once in the given cycle
  task automatic check_end(input logic exp_hs, input usb_out_pkg::tx_hs_t hs,
                           input usb_out_pkg::ep_event_t ev, input int at_cyc,
                           input string what);
    check_count(tx_q.size(), exp_hs ? 1 : 0, {what, " handshake count"});
    if (exp_hs && tx_q.size() == 1) begin
      check_hs(tx_q[0], hs, {what, " handshake"});
      check_count(tx_cyc_q[0], at_cyc, {what, " handshake cycle"});
    end
    check_count(ev_q.size(), (ev != '0) ? 1 : 0, {what, " event count"});
    if (ev != '0 && ev_q.size() == 1) begin
      check_event(ev_q[0], ev, {what, " event"});
      check_count(ev_cyc_q[0], at_cyc, {what, " event cycle"});
    end
  endtask

  task automatic check_puts(input string what);
    check_count(put_addr_q.size(), payload.size(), {what, " put count"});
    for (int i = 0; i < put_addr_q.size() && i < payload.size(); i++) begin
      check_offset(put_addr_q[i], PktW'(i), $sformatf("%s put %0d offset", what, i));
      check_byte(put_data_q[i], payload[i], $sformatf("%s put %0d byte", what, i));
    end
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic usb_out_pkg::tx_hs_t make_hs(input usb_out_pkg::usb_pid_e pid);
    usb_out_pkg::tx_hs_t hs;
    hs.start = 1'b1;
    hs.pid   = pid;
    return hs;
  endfunction

  function automatic usb_out_pkg::ep_event_t make_event(input logic acked, rollback);
    usb_out_pkg::ep_event_t ev;
    ev.newpkt   = 1'b0;
    ev.acked    = acked;
    ev.rollback = rollback;
    return ev;
  endfunction

  function automatic usb_out_pkg::usb_pid_e data_pid(input logic tog);
    return tog ? usb_out_pkg::UsbPidData1 : usb_out_pkg::UsbPidData0;
  endfunction

  task automatic clear_log();
    tx_q.delete();
    tx_cyc_q.delete();
    ev_q.delete();
    ev_cyc_q.delete();
    put_addr_q.delete();
    put_data_q.delete();
    newpkt_cnt = 0;
  endtask

  // Waits n sampling edges and returns on a rising edge
  task automatic settle(input int n);
    repeat (n) @(negedge clk_48mhz);
    @(posedge clk_48mhz);
  endtask

  task automatic send_token(input usb_out_pkg::usb_pid_e pid,
                            input usb_out_pkg::dev_addr_t addr,
                            input usb_out_pkg::ep_id_t endp);
    @(posedge clk_48mhz);
    rx_pkt.pkt_start <= 1'b1;
    rx_pkt.pkt_valid <= 1'b1;
    rx_pkt.pid       <= pid;
    rx_pkt.addr      <= addr;
    rx_pkt.endp      <= endp;
    @(posedge clk_48mhz);
    rx_pkt.pkt_start <= 1'b0;
    @(posedge clk_48mhz);
    rx_pkt.pkt_end   <= 1'b1;
    @(posedge clk_48mhz);
    rx_pkt.pkt_end   <= 1'b0;
  endtask

  // Receiver keeps endp of the token and bytes arrive every other cycle
  task automatic send_data(input usb_out_pkg::usb_pid_e pid, input usb_out_pkg::ep_id_t endp,
                           input int n_bytes, output int end_cyc);
    usb_out_pkg::byte_t b;
    payload.delete();
    @(posedge clk_48mhz);
    rx_pkt.pkt_start <= 1'b1;
    rx_pkt.pkt_valid <= 1'b1;
    rx_pkt.pid       <= pid;
    rx_pkt.endp      <= endp;
    for (int i = 0; i < n_bytes; i++) begin
      b = usb_out_pkg::byte_t'($random(seed));
      payload.push_back(b);
      @(posedge clk_48mhz);
      rx_pkt.pkt_start <= 1'b0;
      rx_data.put      <= 1'b1;
      rx_data.data     <= b;
      @(posedge clk_48mhz);
      rx_data.put      <= 1'b0;
    end
    @(posedge clk_48mhz);
    rx_pkt.pkt_start <= 1'b0;
    rx_pkt.pkt_end   <= 1'b1;
    @(negedge clk_48mhz);
    end_cyc = cyc;
    @(posedge clk_48mhz);
    rx_pkt.pkt_end   <= 1'b0;
  endtask

  task automatic sw_write(input logic [NumOutEps-1:0] status, mask);
    @(posedge clk_48mhz);
    datatog_we     <= 1'b1;
    datatog_status <= status;
    datatog_mask   <= mask;
    @(posedge clk_48mhz);
    datatog_we     <= 1'b0;
    settle(1);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_good_out();
    int end_cyc;
    clear_log();
    send_token(usb_out_pkg::UsbPidOut, DevAddr, 4'd1);
    send_data(data_pid(exp_tog[1]), 4'd1, 8, end_cyc);
    settle(4);
    check_count(newpkt_cnt, 1, "good OUT newpkt count");
    check_count(int'(cur_seen), 1, "good OUT current endpoint");
    check_puts("good OUT");
    check_end(1'b1, make_hs(usb_out_pkg::UsbPidAck), make_event(1'b1, 1'b0), end_cyc + 1,
              "good OUT");
    exp_tog[1] = ~exp_tog[1];
    check_vec(tog_seen, exp_tog, "good OUT toggles");
  endtask

  // Host missed our ACK and repeats the packet
  task automatic test_bad_toggle();
    int end_cyc;
    clear_log();
    send_token(usb_out_pkg::UsbPidOut, DevAddr, 4'd1);
    send_data(data_pid(~exp_tog[1]), 4'd1, 2, end_cyc);
    settle(4);
    check_end(1'b1, make_hs(usb_out_pkg::UsbPidAck), make_event(1'b0, 1'b1), end_cyc,
              "repeated DATA");
    check_vec(tog_seen, exp_tog, "repeated DATA toggles");
  endtask

  task automatic test_full_stall();
    int end_cyc;
    clear_log();
    ep_full <= 2'b10;
    send_token(usb_out_pkg::UsbPidOut, DevAddr, 4'd1);
    send_data(data_pid(exp_tog[1]), 4'd1, 4, end_cyc);
    settle(4);
    check_end(1'b1, make_hs(usb_out_pkg::UsbPidNak), make_event(1'b0, 1'b1), end_cyc + 1,
              "full OUT");
    check_vec(tog_seen, exp_tog, "full OUT toggles");
    clear_log();
    ep_full  <= '0;
    ep_stall <= 2'b10;
    send_token(usb_out_pkg::UsbPidOut, DevAddr, 4'd1);
    send_data(data_pid(exp_tog[1]), 4'd1, 4, end_cyc);
    settle(4);
    check_count(newpkt_cnt, 1, "stalled OUT newpkt count");
    check_end(1'b1, make_hs(usb_out_pkg::UsbPidStall), '0, end_cyc + 1, "stalled OUT");
    check_vec(tog_seen, exp_tog, "stalled OUT toggles");
    ep_stall <= '0;
  endtask

  task automatic test_setup();
    int end_cyc;
    // Bit 0 is loaded with 1 and bit 1 keeps its value
    sw_write(2'b01, 2'b01);
    exp_tog[0] = 1'b1;
    clear_log();
    send_token(usb_out_pkg::UsbPidSetup, DevAddr, 4'd0);
    settle(1);
    // SETUP restarts endpoint 0 at DATA0
    exp_tog[0]   = 1'b0;
    exp_setup[0] = 1'b1;
    check_vec(tog_seen, exp_tog, "SETUP token toggles");
    check_vec(setup_seen, exp_setup, "SETUP flags");
    send_data(data_pid(exp_tog[0]), 4'd0, 8, end_cyc);
    settle(4);
    check_count(newpkt_cnt, 1, "SETUP newpkt count");
    check_puts("SETUP");
    check_end(1'b1, make_hs(usb_out_pkg::UsbPidAck), make_event(1'b1, 1'b0), end_cyc + 1,
              "SETUP");
    exp_tog[0] = 1'b1;
    check_vec(tog_seen, exp_tog, "SETUP data toggles");
  endtask

  task automatic test_setup_rejected();
    int end_cyc;
    clear_log();
    send_token(usb_out_pkg::UsbPidSetup, DevAddr, 4'd1);
    send_data(usb_out_pkg::UsbPidData0, 4'd1, 2, end_cyc);
    settle(4);
    check_count(newpkt_cnt, 0, "SETUP on bulk endpoint newpkt count");
    check_count(put_addr_q.size(), 0, "SETUP on bulk endpoint put count");
    check_end(1'b0, make_hs(usb_out_pkg::UsbPidAck), '0, 0, "SETUP on bulk endpoint");
    clear_log();
    ep_full <= 2'b01;
    send_token(usb_out_pkg::UsbPidSetup, DevAddr, 4'd0);
    send_data(usb_out_pkg::UsbPidData0, 4'd0, 4, end_cyc);
    settle(4);
    check_count(newpkt_cnt, 1, "full SETUP newpkt count");
    check_end(1'b0, make_hs(usb_out_pkg::UsbPidAck), make_event(1'b0, 1'b1), end_cyc + 1,
              "full SETUP");
    check_count(int'(tog_seen[0]), 0, "full SETUP toggle 0");
    ep_full <= '0;
  endtask

  task automatic test_ignored();
    int end_cyc;
    clear_log();
    send_token(usb_out_pkg::UsbPidOut, DevAddr ^ 7'h01, 4'd1);
    send_token(usb_out_pkg::UsbPidOut, DevAddr, 4'd5);
    ep_enabled <= 2'b01;
    send_token(usb_out_pkg::UsbPidOut, DevAddr, 4'd1);
    ep_enabled <= 2'b11;
    settle(4);
    check_count(newpkt_cnt, 0, "ignored tokens newpkt count");
    check_end(1'b0, make_hs(usb_out_pkg::UsbPidAck), '0, 0, "ignored tokens");
    // Data comes well after the countdown has expired
    clear_log();
    send_token(usb_out_pkg::UsbPidOut, DevAddr, 4'd1);
    repeat (AckTimeoutCnt + 12) @(posedge clk_48mhz);
    send_data(usb_out_pkg::UsbPidData0, 4'd1, 2, end_cyc);
    settle(4);
    check_count(newpkt_cnt, 1, "late data newpkt count");
    check_count(put_addr_q.size(), 0, "late data put count");
    check_end(1'b0, make_hs(usb_out_pkg::UsbPidAck), '0, 0, "late data");
  endtask

  task automatic test_sw_link_reset();
    sw_write(2'b11, 2'b11);
    exp_tog = 2'b11;
    check_vec(tog_seen, exp_tog, "full mask write");
    // Only bit 1 is written and bit 0 keeps its 1
    sw_write(2'b00, 2'b10);
    exp_tog = 2'b01;
    check_vec(tog_seen, exp_tog, "masked write");
    @(posedge clk_48mhz);
    link_reset <= 1'b1;
    @(posedge clk_48mhz);
    link_reset <= 1'b0;
    settle(1);
    exp_tog = '0;
    check_vec(tog_seen, exp_tog, "link reset toggles");
  endtask

  initial begin
    link_reset     = 1'b0;
    dev_addr       = DevAddr;
    rx_pkt         = '0;
    rx_data        = '0;
    ep_enabled     = 2'b11;
    ep_control     = 2'b01;
    ep_full        = '0;
    ep_stall       = '0;
    datatog_we     = 1'b0;
    datatog_status = '0;
    datatog_mask   = '0;
    exp_tog        = '0;
    exp_setup      = '0;
    n_checks       = 0;
    n_errors       = 0;
    @(posedge rst_n);
    settle(2);
    test_good_out();
    test_bad_toggle();
    test_full_stall();
    test_setup();
    test_setup_rejected();
    test_ignored();
    test_sw_link_reset();
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- sources.f
usb_out_pkg.sv
usb_out_token_decode.sv
usb_out_xact_fsm.sv
usb_out_data_path.sv
usb_out_toggle_regs.sv
usb_out_pe.sv
tb_clk_gen.sv
tb_usb_out_pe.sv
